//--- verification/spi_golden.mem
// type argument model response led img_rst_ header, all hex
// model is answer flag, error flag, read data; response counts only when type bit 7 is set
80 0123456789abcdef 000000 0123456789abcdef 0 0 00000000000000000000000000000000
01 ffffffff0000000a 000000 0000000000000000 a 0 00000000000000000000000000000000
02 0000000000000001 000000 0000000000000000 a 1 00000000000000000000000000000000
00 ffffffffffffffff 000000 0000000000000000 a 1 00000000000000000000000000000000
42 000000000000000f 000000 0000000000000000 a 1 00000000000000000000000000000000
03 ff11223344556677 000000 0000000000000000 a 1 11223344556677000000000000000000
04 ee8899aabbccddee 000000 0000000000000000 a 1 112233445566778899aabbccddee0000
80 fedcba9876543210 000000 fedcba9876543210 a 1 112233445566778899aabbccddee0000
01 0000000000000005 000000 0000000000000000 5 1 112233445566778899aabbccddee0000
02 fffffffffffffffe 000000 0000000000000000 5 0 112233445566778899aabbccddee0000
91 123456789abcdef0 000000 0000000000000000 5 0 112233445566778899aabbccddee0000
86 0000000000000000 000000 0000000000000000 5 0 112233445566778899aabbccddee0000
05 c1233a5c999900c7 000000 0000000000000000 5 0 112233445566778899aabbccddee0000
86 0000000000000000 000000 0000000000000000 5 0 112233445566778899aabbccddee0000
00 0000000000000000 11beef 0000000000000000 5 0 112233445566778899aabbccddee0000
86 0000000000000000 000000 c00000000000beef 5 0 112233445566778899aabbccddee0000
05 0000010100005a5a 000000 0000000000000000 5 0 112233445566778899aabbccddee0000
86 0000000000000000 000000 400000000000beef 5 0 112233445566778899aabbccddee0000
00 0000000000000000 101234 0000000000000000 5 0 112233445566778899aabbccddee0000
86 0000000000000000 000000 8000000000001234 5 0 112233445566778899aabbccddee0000

//--- build.f
+incdir+design
design/msg_pkg.sv
design/periph_pkg.sv
design/msg_shifter.sv
design/cmd_decoder.sv
design/resp_shifter.sv
design/done_tracker.sv
design/spi_top.sv
verification/tb_spi_top.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_spi_top
RTL_TOP    := spi_top
FILELIST   := build.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
OBJ_DIR    := obj_dir
PASS_TEXT  := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_spi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module tb_spi_top
    import msg_pkg::*;
    import periph_pkg::*;
();

    // Columns per test line: type, argument, model, response, led, img_rst_, header
    localparam int unsigned golden_cols     = 7;
    localparam int unsigned max_lines       = 64;
    localparam int unsigned mem_depth       = golden_cols * max_lines;
    localparam int unsigned cycles_per_line = 200;

    logic               spi_clk = 1'b0;
    logic               spi_rst_;
    logic               data_in;
    logic               data_out;
    logic               data_oe;
    logic [`LED_W-1:0]  led;
    logic               img_rst_;
    img_header_t        img_header;
    i2c_cmd_t           i2c_cmd;
    logic               i2c_trigger;
    logic               i2c_done;
    i2c_status_t        i2c_status;

    logic [127:0] golden_mem [0:mem_depth-1];
    int unsigned  line_count;
    int unsigned  cycle_limit;
    int unsigned  cycle_cnt = 0;

    // Set per test line, read by the I2C model
    logic         answer_ok;
    i2c_status_t  model_status;

    spi_top u_spi_top (
        .spi_clk     (spi_clk),
        .spi_rst_    (spi_rst_),
        .data_in     (data_in),
        .data_out    (data_out),
        .data_oe     (data_oe),
        .led         (led),
        .img_rst_    (img_rst_),
        .img_header  (img_header),
        .i2c_cmd     (i2c_cmd),
        .i2c_trigger (i2c_trigger),
        .i2c_done    (i2c_done),
        .i2c_status  (i2c_status)
    );

    always #5 spi_clk = ~spi_clk;

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] expected);
        if (got !== expected) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Result: FAILED");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    // Start bit, message, turnaround and response window on the serial line
    task automatic send_message(input logic [`MSG_TYPE_W-1:0] msg_type,
                                input logic [`MSG_ARG_W-1:0] arg,
                                input logic resp_on,
                                output logic [`RESP_LEN-1:0] resp_bits);
        logic [`MSG_LEN-1:0] frame;
        int i;
        frame = {msg_type, arg};
        resp_bits = '0;
        @(negedge spi_clk);
        data_in = 1'b1;
        check_value("data_oe at start bit", 128'(data_oe), '0);
        for (i = `MSG_LEN - 1; i >= 0; i--) begin
            @(negedge spi_clk);
            data_in = frame[i];
            check_value("data_oe during message", 128'(data_oe), '0);
        end
        for (i = 0; i < `TURNAROUND_CYCLES - 1; i++) begin
            @(negedge spi_clk);
            data_in = 1'b0;
            check_value("data_oe during turnaround", 128'(data_oe), '0);
        end
        // Each falling edge shows what the next rising edge samples
        for (i = 0; i < `RESP_LEN; i++) begin
            @(negedge spi_clk);
            check_value("data_oe in response window", 128'(data_oe), 128'(resp_on));
            resp_bits[`RESP_LEN - 1 - i] = data_out;
        end
        @(negedge spi_clk);
        check_value("data_oe after response", 128'(data_oe), '0);
    endtask

    task automatic run_test_lines();
        int unsigned             line;
        int unsigned             base;
        logic [`MSG_TYPE_W-1:0]  msg_type;
        logic [`MSG_ARG_W-1:0]   arg;
        logic [23:0]             model_word;
        logic [`RESP_LEN-1:0]    exp_resp;
        logic [`RESP_LEN-1:0]    got_resp;
        logic [`LED_W-1:0]       exp_led;
        logic                    exp_rst;
        img_header_t             exp_header;
        i2c_cmd_t                exp_cmd;
        logic                    exp_trigger;
        logic                    resp_on;
        exp_cmd = '0;
        exp_trigger = 1'b0;
        for (line = 0; line < line_count; line++) begin
            base       = line * golden_cols;
            msg_type   = golden_mem[base][`MSG_TYPE_W-1:0];
            arg        = golden_mem[base + 1][`MSG_ARG_W-1:0];
            model_word = golden_mem[base + 2][23:0];
            exp_resp   = golden_mem[base + 3][`RESP_LEN-1:0];
            exp_led    = golden_mem[base + 4][`LED_W-1:0];
            exp_rst    = golden_mem[base + 5][0];
            exp_header = golden_mem[base + 6];
            model_status.err       = model_word[16];
            model_status.read_data = model_word[15:0];
            answer_ok              = model_word[20];
            resp_on = msg_type[type_resp_bit];
            // Field layout of the I2C request
            if (msg_type == msg_img_i2c_transaction) begin
                exp_cmd.write      = arg[63];
                exp_cmd.two_byte   = arg[62];
                exp_cmd.reg_addr   = arg[47:32];
                exp_cmd.write_data = arg[15:0];
                exp_trigger        = ~exp_trigger;
            end
            send_message(msg_type, arg, resp_on, got_resp);
            if (resp_on) begin
                check_value("response", 128'(got_resp), 128'(exp_resp));
            end
            check_value("led", 128'(led), 128'(exp_led));
            check_value("img_rst_", 128'(img_rst_), 128'(exp_rst));
            check_value("img_header", 128'(img_header), 128'(exp_header));
            check_value("i2c_cmd", 128'(i2c_cmd), 128'(exp_cmd));
            check_value("i2c_trigger", 128'(i2c_trigger), 128'(exp_trigger));
        end
    endtask

    // ========================================
    // I2C engine model
    // ========================================
    initial begin
        logic        seen_trigger;
        logic [31:0] rand_state;
        int unsigned delay;
        seen_trigger = 1'b0;
        rand_state   = 32'he7db_20cb;
        i2c_done     = 1'b0;
        i2c_status   = '0;
        forever begin
            @(negedge spi_clk);
            if (i2c_trigger !== seen_trigger) begin
                seen_trigger = i2c_trigger;
                // Request is held until a test line lets it finish
                while (!answer_ok) begin
                    @(negedge spi_clk);
                end
                i2c_status = model_status;
                rand_state = xorshift32(rand_state);
                delay = 5 + rand_state % 16;
                repeat (delay) @(negedge spi_clk);
                i2c_done = ~i2c_done;
            end
        end
    end

    always @(posedge spi_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Result: FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int unsigned a;
        spi_rst_     = 1'b0;
        data_in      = 1'b0;
        answer_ok    = 1'b0;
        model_status = '0;
        cycle_limit  = 0;
        for (a = 0; a < mem_depth; a++) begin
            golden_mem[a] = {4{~a}};
        end
        $readmemh("verification/spi_golden.mem", golden_mem);
        // Type column is 8 bits wide, so the fill marks the end of the data
        line_count = 0;
        while (line_count < max_lines
               && golden_mem[line_count * golden_cols][127:8] == '0) begin
            line_count++;
        end
        cycle_limit = line_count * cycles_per_line;
        repeat (5) @(posedge spi_clk);
        @(negedge spi_clk);
        spi_rst_ = 1'b1;
        check_value("data_oe after reset", 128'(data_oe), '0);
        check_value("data_out after reset", 128'(data_out), '0);
        check_value("led after reset", 128'(led), '0);
        check_value("img_rst_ after reset", 128'(img_rst_), '0);
        check_value("img_header after reset", 128'(img_header), '0);
        check_value("i2c_cmd after reset", 128'(i2c_cmd), '0);
        check_value("i2c_trigger after reset", 128'(i2c_trigger), '0);
        if (line_count == 0) begin
            $display("No test lines found in verification/spi_golden.mem");
            $display("Result: FAILED");
            $fatal(1, "empty stimulus file");
        end else begin
            run_test_lines();
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- design/spi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_top
    import msg_pkg::*;
    import periph_pkg::*;
(
    input  wire logic          spi_clk,
    input  wire logic          spi_rst_,
    input  wire logic          data_in,
    output logic               data_out,
    output logic               data_oe,
    output logic [`LED_W-1:0]  led,
    output logic               img_rst_,
    output img_header_t        img_header,
    output i2c_cmd_t           i2c_cmd,
    output logic               i2c_trigger,
    input  wire logic          i2c_done,
    input  wire i2c_status_t   i2c_status
);

    msg_t  msg;
    logic  msg_valid;
    resp_t resp;
    logic  resp_load;
    logic  resp_expected;
    logic  i2c_pending;
    logic  ack_req;

    // ========================================
    // Receive path
    // ========================================
    msg_shifter u_msg_shifter (
        .spi_clk   (spi_clk),
        .spi_rst_  (spi_rst_),
        .data_in   (data_in),
        .msg       (msg),
        .msg_valid (msg_valid)
    );

    cmd_decoder u_cmd_decoder (
        .spi_clk       (spi_clk),
        .spi_rst_      (spi_rst_),
        .msg           (msg),
        .msg_valid     (msg_valid),
        .i2c_pending   (i2c_pending),
        .i2c_status    (i2c_status),
        .resp          (resp),
        .resp_load     (resp_load),
        .resp_expected (resp_expected),
        .led           (led),
        .img_rst_      (img_rst_),
        .img_header    (img_header),
        .i2c_cmd       (i2c_cmd),
        .i2c_trigger   (i2c_trigger),
        .ack_req       (ack_req)
    );

    // ========================================
    // Response and I2C done
    // ========================================
    resp_shifter u_resp_shifter (
        .spi_clk       (spi_clk),
        .spi_rst_      (spi_rst_),
        .resp          (resp),
        .resp_load     (resp_load),
        .resp_expected (resp_expected),
        .data_out      (data_out),
        .data_oe       (data_oe)
    );

    done_tracker u_done_tracker (
        .spi_clk     (spi_clk),
        .spi_rst_    (spi_rst_),
        .done_toggle (i2c_done),
        .ack_req     (ack_req),
        .pending     (i2c_pending)
    );

endmodule

`default_nettype wire

//--- design/done_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module done_tracker (
    input  wire logic spi_clk,
    input  wire logic spi_rst_,
    input  wire logic done_toggle,
    input  wire logic ack_req,
    output logic      pending
);

    logic done_meta;
    logic done_sync;
    logic ack_toggle;

    // done_toggle comes from the I2C engine clock
    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            done_meta  <= 1'b0;
            done_sync  <= 1'b0;
            ack_toggle <= 1'b0;
        end else begin
            done_meta <= done_toggle;
            done_sync <= done_meta;
            if (ack_req) begin
                ack_toggle <= ~ack_toggle;
            end
        end
    end

    // Done seen but not yet acknowledged
    assign pending = done_sync ^ ack_toggle;

endmodule

`default_nettype wire

//--- design/resp_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module resp_shifter
    import msg_pkg::*;
(
    input  wire logic  spi_clk,
    input  wire logic  spi_rst_,
    input  wire resp_t resp,
    input  wire logic  resp_load,
    input  wire logic  resp_expected,
    output logic       data_out,
    output logic       data_oe
);

    localparam int unsigned cnt_w = $clog2(`RESP_LEN);
    // Decoder, load, output flop and host sample edge use 4 of the turnaround
    localparam logic [cnt_w-1:0] wait_load  = cnt_w'(`TURNAROUND_CYCLES - 4);
    localparam logic [cnt_w-1:0] shift_load = cnt_w'(`RESP_LEN - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_shift
    } state_t;

    state_t           state;
    logic [cnt_w-1:0] cnt;
    resp_t            shift_q;

    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state    <= st_idle;
            cnt      <= '0;
            data_out <= 1'b0;
            data_oe  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (resp_load && resp_expected) begin
                        state <= st_wait;
                        cnt   <= wait_load;
                    end
                end
                st_wait: begin
                    if (cnt == '0) begin
                        state    <= st_shift;
                        cnt      <= shift_load;
                        data_oe  <= 1'b1;
                        data_out <= shift_q[`RESP_LEN-1];
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    if (cnt == '0) begin
                        state    <= st_idle;
                        data_oe  <= 1'b0;
                        data_out <= 1'b0;
                    end else begin
                        cnt      <= cnt - 1'b1;
                        data_out <= shift_q[`RESP_LEN-1];
                    end
                end
            endcase
        end
    end

    // Word is captured on load and moves up one bit per driven bit
    always_ff @(posedge spi_clk) begin
        if (state == st_idle && resp_load) begin
            shift_q <= resp;
        end else if ((state == st_wait && cnt == '0) || state == st_shift) begin
            shift_q <= {shift_q[`RESP_LEN-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- design/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module cmd_decoder
    import msg_pkg::*;
    import periph_pkg::*;
(
    input  wire logic          spi_clk,
    input  wire logic          spi_rst_,
    input  wire msg_t          msg,
    input  wire logic          msg_valid,
    input  wire logic          i2c_pending,
    input  wire i2c_status_t   i2c_status,
    output resp_t              resp,
    output logic               resp_load,
    output logic               resp_expected,
    output logic [`LED_W-1:0]  led,
    output logic               img_rst_,
    output img_header_t        img_header,
    output i2c_cmd_t           i2c_cmd,
    output logic               i2c_trigger,
    output logic               ack_req
);

    // Header halves fill the upper 112 bits and leave the bottom 16 at zero
    localparam int unsigned hdr1_top = `HEADER_W - 1;
    localparam int unsigned hdr2_top = `HEADER_W - `HEADER_PART_W - 1;

    // ========================================
    // Output registers
    // ========================================
    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            resp_load     <= 1'b0;
            resp_expected <= 1'b0;
            led           <= '0;
            img_rst_      <= 1'b0;
            img_header    <= '0;
            i2c_cmd       <= '0;
            i2c_trigger   <= 1'b0;
            ack_req       <= 1'b0;
        end else begin
            resp_load <= msg_valid;
            ack_req   <= 1'b0;
            if (msg_valid) begin
                resp_expected <= msg.msg_type[type_resp_bit];
                case (msg.msg_type)
                    msg_led_set: begin
                        led <= msg.arg[`LED_W-1:0];
                    end
                    msg_img_reset: begin
                        img_rst_ <= msg.arg[0];
                    end
                    msg_img_set_header1: begin
                        img_header[hdr1_top -: `HEADER_PART_W] <= msg.arg[`HEADER_PART_W-1:0];
                    end
                    msg_img_set_header2: begin
                        img_header[hdr2_top -: `HEADER_PART_W] <= msg.arg[`HEADER_PART_W-1:0];
                    end
                    msg_img_i2c_transaction: begin
                        i2c_cmd.write      <= msg.arg[63];
                        i2c_cmd.two_byte   <= msg.arg[62];
                        i2c_cmd.reg_addr   <= msg.arg[32 +: `I2C_ADDR_W];
                        i2c_cmd.write_data <= msg.arg[`I2C_DATA_W-1:0];
                        i2c_trigger        <= ~i2c_trigger;
                        // Retire the old done before the new request goes out
                        if (i2c_pending) begin
                            ack_req <= 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // ========================================
    // Response word
    // ========================================
    always_ff @(posedge spi_clk) begin
        if (msg_valid) begin
            resp <= '0;
            case (msg.msg_type)
                msg_echo: begin
                    resp <= resp_t'(msg.arg);
                end
                msg_img_i2c_status: begin
                    resp[`RESP_LEN-1]          <= i2c_pending;
                    resp[`RESP_LEN-2]          <= i2c_status.err;
                    resp[`I2C_DATA_W-1:0]      <= i2c_status.read_data;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/msg_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module msg_shifter
    import msg_pkg::*;
(
    input  wire logic spi_clk,
    input  wire logic spi_rst_,
    input  wire logic data_in,
    output msg_t      msg,
    output logic      msg_valid
);

    localparam int unsigned cnt_w = $clog2(`MSG_LEN);
    localparam logic [cnt_w-1:0] last_bit = cnt_w'(`MSG_LEN - 1);

    logic             busy;
    logic [cnt_w-1:0] bit_cnt;
    logic [`MSG_LEN-1:0] shift_q;

    // ========================================
    // Framing
    // ========================================
    always_ff @(posedge spi_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            busy      <= 1'b0;
            bit_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            if (!busy) begin
                // A high bit on the idle line is the start bit
                if (data_in) begin
                    busy    <= 1'b1;
                    bit_cnt <= last_bit;
                end
            end else if (bit_cnt == '0) begin
                busy      <= 1'b0;
                msg_valid <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    // MSB first, so new bits enter at the bottom
    always_ff @(posedge spi_clk) begin
        if (busy) begin
            shift_q <= {shift_q[`MSG_LEN-2:0], data_in};
        end
    end

    assign msg = msg_t'(shift_q);

endmodule

`default_nettype wire

//--- design/periph_pkg.sv
`default_nettype none

`include "spi_defines.svh"

package periph_pkg;

    // Request to the image sensor I2C engine
    typedef struct packed {
        logic                   write;
        logic [`I2C_ADDR_W-1:0] reg_addr;
        logic                   two_byte;
        logic [`I2C_DATA_W-1:0] write_data;
    } i2c_cmd_t;

    // Result of the last I2C transaction
    typedef struct packed {
        logic                   err;
        logic [`I2C_DATA_W-1:0] read_data;
    } i2c_status_t;

    typedef logic [`HEADER_W-1:0] img_header_t;

endpackage

`default_nettype wire

//--- design/msg_pkg.sv
`default_nettype none

`include "spi_defines.svh"

package msg_pkg;

    // Bit 7 of the type marks a message that gets a response
    localparam int unsigned type_resp_bit = 7;

    typedef enum logic [`MSG_TYPE_W-1:0] {
        msg_nop                 = 8'h00,
        msg_led_set             = 8'h01,
        msg_img_reset           = 8'h02,
        msg_img_set_header1     = 8'h03,
        msg_img_set_header2     = 8'h04,
        msg_img_i2c_transaction = 8'h05,
        msg_echo                = 8'h80,
        msg_img_i2c_status      = 8'h86
    } msg_type_t;

    // Type goes out first on the line, so it sits in the upper bits
    typedef struct packed {
        msg_type_t              msg_type;
        logic [`MSG_ARG_W-1:0]  arg;
    } msg_t;

    typedef logic [`RESP_LEN-1:0] resp_t;

endpackage

`default_nettype wire

//--- design/spi_defines.svh
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// Message framing
`define MSG_TYPE_W          8
`define MSG_ARG_W           64
`define MSG_LEN             72

// Response framing
`define RESP_LEN            64

// Rising edges from the last message bit to the first response bit
`define TURNAROUND_CYCLES   8

// Output registers
`define LED_W               4
`define HEADER_W            128
`define HEADER_PART_W       56

// Image sensor I2C fields
`define I2C_ADDR_W          16
`define I2C_DATA_W          16

`endif
